// ==== cv_config_regs.sv ====
`default_nettype none

module cv_config_regs (
    input  wire                   clk_sys,
    input  wire                   reset,
    input  wire cv_pkg::cv_axil_req_t axil_req_i,
    output cv_pkg::cv_axil_rsp_t  axil_rsp_o,
    input  wire                   dahjee_i,
    output cv_pkg::cv_cfg_t       cfg_o
);
    import cv_pkg::*;

    logic                  awready_q;
    logic                  bvalid_q;
    logic                  arready_q;
    logic                  rvalid_q;
    logic [AXI_DATA_W-1:0] rdata_q;
    logic                  wr_hs;
    logic                  rd_hs;

    // Handshake completes in the cycle the ready pulse is seen
    assign wr_hs = awready_q && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_hs = arready_q && axil_req_i.arvalid;

    // --------------------------------------------------
    // Write channel and config word
    // --------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            cfg_o     <= '0;
        end else begin
            awready_q <= 1'b0;
            if (axil_req_i.awvalid && axil_req_i.wvalid && !awready_q && !bvalid_q) begin
                awready_q <= 1'b1;
            end
            if (wr_hs) begin
                bvalid_q <= 1'b1;
                // Only the defined fields are kept
                if (axil_req_i.awaddr == REG_CFG_ADDR) begin
                    cfg_o <= cv_cfg_t'(axil_req_i.wdata[CFG_W-1:0]);
                end
            end else if (bvalid_q && axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Read channel
    // --------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= axil_req_i.arvalid && !arready_q && !rvalid_q;
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rd_hs) begin
            case (axil_req_i.araddr)
                REG_CFG_ADDR:  rdata_q <= {{(AXI_DATA_W-CFG_W){1'b0}}, cfg_o};
                REG_STAT_ADDR: rdata_q <= {{(AXI_DATA_W-1){1'b0}}, dahjee_i};
                default:       rdata_q <= '0;
            endcase
        end
    end

    always_comb begin
        axil_rsp_o.awready = awready_q;
        axil_rsp_o.wready  = awready_q;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.bresp   = AXI_RESP_OKAY;
        axil_rsp_o.arready = arready_q;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = AXI_RESP_OKAY;
    end

endmodule

`default_nettype wire

// ==== cv_controller_ports.sv ====
`default_nettype none

module cv_controller_ports (
    input  wire                   clk_sys,
    input  wire                   reset,
    input  wire cv_pkg::cv_cfg_t  cfg_i,
    input  wire cv_pkg::cv_ctrl_sel_t ctrl_sel_i [cv_pkg::NUM_PORTS],
    input  wire cv_pkg::cv_joy_t  joy0_i,
    input  wire cv_pkg::cv_joy_t  joy1_i,
    input  wire [15:0]            ps2_keys_i,
    input  wire [4:0]             ps2_joy_i,
    output cv_pkg::cv_ctrl_out_t  ctrl_o [cv_pkg::NUM_PORTS]
);
    import cv_pkg::*;

    logic [SPIN_DIV_BITS-1:0] spin_cnt;
    logic                     spin_step;
    logic [3:0]               key_code;
    cv_joy_t                  joy_sel [NUM_PORTS];

    // Spinner enable, one pulse per counter wrap
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            spin_cnt <= '0;
        end else begin
            spin_cnt <= spin_cnt + 1'b1;
        end
    end

    assign spin_step = (spin_cnt == '0);

    assign joy_sel[0] = cfg_i.joyswap ? joy1_i : joy0_i;
    assign joy_sel[1] = cfg_i.joyswap ? joy0_i : joy1_i;

    // Keyboard keys in priority order, 1 to 9 then 0, * and #
    always_comb begin
        if      (ps2_keys_i[13]) key_code = 4'd1;
        else if (ps2_keys_i[7])  key_code = 4'd2;
        else if (ps2_keys_i[12]) key_code = 4'd3;
        else if (ps2_keys_i[2])  key_code = 4'd4;
        else if (ps2_keys_i[3])  key_code = 4'd5;
        else if (ps2_keys_i[14]) key_code = 4'd6;
        else if (ps2_keys_i[5])  key_code = 4'd7;
        else if (ps2_keys_i[1])  key_code = 4'd8;
        else if (ps2_keys_i[11]) key_code = 4'd9;
        else if (ps2_keys_i[10]) key_code = 4'd0;
        else if (ps2_keys_i[9])  key_code = KEY_STAR;
        else if (ps2_keys_i[6])  key_code = KEY_HASH;
        else                     key_code = KEY_NONE;
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        cv_pins_u   pins;
        logic       fire;
        logic [1:0] quad;

        always_comb begin
            if (!ctrl_sel_i[p].sel_joy && ctrl_sel_i[p].sel_key) begin
                // Keypad and right button
                pins.key_pattern = CV_KEYS[key_code];
                fire             = ~(ps2_keys_i[0] | joy_sel[p].fire2);
            end else if (ctrl_sel_i[p].sel_joy && !ctrl_sel_i[p].sel_key) begin
                // Joystick and left button
                pins.joy.up    = ~(ps2_joy_i[0] | joy_sel[p].up);
                pins.joy.down  = ~(ps2_joy_i[1] | joy_sel[p].down);
                pins.joy.left  = ~(ps2_joy_i[2] | joy_sel[p].left);
                pins.joy.right = ~(ps2_joy_i[3] | joy_sel[p].right);
                fire           = ~(ps2_joy_i[4] | joy_sel[p].fire1);
            end else begin
                pins.key_pattern = 4'b1111;
                fire             = 1'b1;
            end
        end

        cv_spinner u_spinner (
            .clk_sys  (clk_sys),
            .reset    (reset),
            .enable_i (cfg_i.spinner_en),
            .step_i   (spin_step),
            .left_i   (joy_sel[p].left),
            .right_i  (joy_sel[p].right),
            .quad_o   (quad)
        );

        assign ctrl_o[p] = '{pins: pins, fire: fire, quad: quad};
    end

endmodule

`default_nettype wire

// ==== cv_glue_top.sv ====
`default_nettype none

module cv_glue_top (
    input  wire                           clk_sys,
    input  wire                           reset,
    input  wire cv_pkg::cv_axil_req_t     axil_req_i,
    output cv_pkg::cv_axil_rsp_t          axil_rsp_o,
    input  wire cv_pkg::cv_ctrl_sel_t     ctrl_sel_i [cv_pkg::NUM_PORTS],
    input  wire cv_pkg::cv_joy_t          joy0_i,
    input  wire cv_pkg::cv_joy_t          joy1_i,
    input  wire [15:0]                    ps2_keys_i,
    input  wire [4:0]                     ps2_joy_i,
    output cv_pkg::cv_ctrl_out_t          ctrl_o [cv_pkg::NUM_PORTS],
    input  wire [cv_pkg::CPU_ADDR_W-1:0]  cpu_ram_a_i,
    output logic [cv_pkg::CPU_ADDR_W-1:0] ram_a_o,
    input  wire cv_pkg::cv_dl_t           dl_i,
    output logic                          console_reset_o
);
    import cv_pkg::*;

    cv_cfg_t cfg;
    logic    dahjee;

    cv_config_regs u_config_regs (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .dahjee_i   (dahjee),
        .cfg_o      (cfg)
    );

    cv_controller_ports u_controller_ports (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .cfg_i      (cfg),
        .ctrl_sel_i (ctrl_sel_i),
        .joy0_i     (joy0_i),
        .joy1_i     (joy1_i),
        .ps2_keys_i (ps2_keys_i),
        .ps2_joy_i  (ps2_joy_i),
        .ctrl_o     (ctrl_o)
    );

    cv_ram_map u_ram_map (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .cfg_i       (cfg),
        .cpu_ram_a_i (cpu_ram_a_i),
        .dl_i        (dl_i),
        .ram_a_o     (ram_a_o),
        .dahjee_o    (dahjee)
    );

    // Console held in reset during a download as well
    always_ff @(posedge clk_sys) begin
        console_reset_o <= reset | cfg.soft_reset | dl_i.active;
    end

endmodule

`default_nettype wire

// ==== cv_pkg.sv ====
`default_nettype none

package cv_pkg;

    // --------------------------------------------------
    // Widths and register map
    // --------------------------------------------------
    localparam int CPU_ADDR_W    = 15;
    localparam int ROM_ADDR_W    = 16;
    localparam int SPIN_DIV_BITS = 16;
    localparam int NUM_PORTS     = 2;
    localparam int AXI_ADDR_W    = 4;
    localparam int AXI_DATA_W    = 32;

    localparam logic [AXI_ADDR_W-1:0] REG_CFG_ADDR  = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_STAT_ADDR = 4'h4;
    localparam logic [1:0]            AXI_RESP_OKAY = 2'b00;

    // Dahjee checksum window starts here, value FF means the expansion is present
    localparam logic [ROM_ADDR_W-1:0] DAHJEE_CHK_ADDR = 16'h2000;
    localparam logic [7:0]            DAHJEE_CHK_VAL  = 8'hFF;

    // Keypad codes beyond the digits
    localparam logic [3:0] KEY_STAR = 4'd10;
    localparam logic [3:0] KEY_HASH = 4'd11;
    localparam logic [3:0] KEY_NONE = 4'd12;

    // Pin patterns per key code, pin 1 in the MSB
    localparam logic [3:0] CV_KEYS [13] = '{
        4'b0011, 4'b1110, 4'b1101, 4'b0110, 4'b0001, 4'b1001, 4'b0111,
        4'b1100, 4'b1000, 4'b1011, 4'b1010, 4'b0101, 4'b1111
    };

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef enum logic [1:0] {
        RAM_1K  = 2'd0,
        RAM_8K  = 2'd1,
        RAM_SGM = 2'd2
    } cv_ram_size_e;

    typedef struct packed {
        cv_ram_size_e ram_size;
        logic         spinner_en;
        logic         joyswap;
        logic         sg1000;
        logic         soft_reset;
    } cv_cfg_t;

    localparam int CFG_W = $bits(cv_cfg_t);

    typedef struct packed {
        logic [1:0] spare;
        logic       fire2;
        logic       fire1;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } cv_joy_t;

    typedef struct packed {
        logic sel_joy;
        logic sel_key;
    } cv_ctrl_sel_t;

    // Pins 1 to 4, read as a keypad pattern or as joystick directions
    typedef union packed {
        logic [3:0] key_pattern;
        struct packed {
            logic up;
            logic down;
            logic left;
            logic right;
        } joy;
    } cv_pins_u;

    typedef struct packed {
        cv_pins_u   pins;
        logic       fire;
        logic [1:0] quad;
    } cv_ctrl_out_t;

    typedef struct packed {
        logic                  active;
        logic                  wr;
        logic [ROM_ADDR_W-1:0] addr;
        logic [7:0]            data;
    } cv_dl_t;

    typedef struct packed {
        logic                  awvalid;
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  wvalid;
        logic [AXI_DATA_W-1:0] wdata;
        logic                  bready;
        logic                  arvalid;
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  rready;
    } cv_axil_req_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [AXI_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
    } cv_axil_rsp_t;

endpackage

`default_nettype wire

// ==== cv_ram_map.sv ====
`default_nettype none

module cv_ram_map (
    input  wire                            clk_sys,
    input  wire                            reset,
    input  wire cv_pkg::cv_cfg_t           cfg_i,
    input  wire [cv_pkg::CPU_ADDR_W-1:0]   cpu_ram_a_i,
    input  wire cv_pkg::cv_dl_t            dl_i,
    output logic [cv_pkg::CPU_ADDR_W-1:0]  ram_a_o,
    output logic                           dahjee_o
);
    import cv_pkg::*;

    logic [7:0] chksum;
    logic       dl_active_q;
    logic       in_window;

    // --------------------------------------------------
    // Address mapping, first match wins
    // --------------------------------------------------
    always_comb begin
        if (cfg_i.sg1000 && dahjee_o) begin
            // Dahjee A, full 32k
            ram_a_o = cpu_ram_a_i;
        end else if (cfg_i.sg1000 && !cpu_ram_a_i[14]) begin
            // 16k at 0x8000 for Basic and a few games
            ram_a_o = {1'b1, cpu_ram_a_i[13:0]};
        end else if (cfg_i.ram_size == RAM_8K) begin
            ram_a_o = CPU_ADDR_W'(cpu_ram_a_i[12:0]);
        end else if (cfg_i.ram_size == RAM_1K) begin
            ram_a_o = CPU_ADDR_W'(cpu_ram_a_i[9:0]);
        end else if (cfg_i.sg1000) begin
            // SGM size on SG-1000 is 16k
            ram_a_o = {1'b0, cpu_ram_a_i[13:0]};
        end else begin
            ram_a_o = cpu_ram_a_i;
        end
    end

    // --------------------------------------------------
    // Dahjee detection
    // --------------------------------------------------
    // Window 0x2000 to 0x3FFF
    assign in_window = (dl_i.addr[ROM_ADDR_W-1:13] == 3'b001);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            chksum      <= '0;
            dahjee_o    <= 1'b0;
            dl_active_q <= 1'b0;
        end else begin
            dl_active_q <= dl_i.active;
            if (cfg_i.sg1000 && dl_i.active) begin
                if (!dl_active_q) begin
                    chksum   <= '0;
                    dahjee_o <= 1'b0;
                end
                if (dl_i.wr && dl_i.addr == DAHJEE_CHK_ADDR) begin
                    chksum <= dl_i.data;
                end else if (dl_i.wr && in_window) begin
                    chksum <= chksum & dl_i.data;
                end
            end
            if (cfg_i.sg1000 && !dl_i.active && chksum == DAHJEE_CHK_VAL) begin
                dahjee_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cv_spinner.sv ====
`default_nettype none

module cv_spinner (
    input  wire        clk_sys,
    input  wire        reset,
    input  wire        enable_i,
    input  wire        step_i,
    input  wire        left_i,
    input  wire        right_i,
    output logic [1:0] quad_o
);

    logic [1:0] quad_left;
    logic [1:0] quad_right;

    // Gray sequence, quad is {pin 7, pin 9}
    always_comb begin
        case (quad_o)
            2'b11:   quad_left = 2'b10;
            2'b10:   quad_left = 2'b00;
            2'b00:   quad_left = 2'b01;
            default: quad_left = 2'b11;
        endcase
        case (quad_o)
            2'b11:   quad_right = 2'b01;
            2'b01:   quad_right = 2'b00;
            2'b00:   quad_right = 2'b10;
            default: quad_right = 2'b11;
        endcase
    end

    // Left takes precedence when both are held
    always_ff @(posedge clk_sys) begin
        if (reset || !enable_i) begin
            quad_o <= 2'b11;
        end else if (step_i) begin
            if (left_i) begin
                quad_o <= quad_left;
            end else if (right_i) begin
                quad_o <= quad_right;
            end
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
cv_pkg.sv
cv_config_regs.sv
cv_spinner.sv
cv_controller_ports.sv
cv_ram_map.sv
cv_glue_top.sv
tb_cv_glue.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cv_glue -f list.f -o sim_cv_glue
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

./obj_dir/sim_cv_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "^Test passed$" "$LOG"
exit $?

// ==== tb_cv_glue.sv ====
`default_nettype none

module tb_cv_glue;
    timeunit 1ns;
    timeprecision 1ps;

    import cv_pkg::*;

    // Nine spinner periods plus a few thousand cycles for the other tests
    localparam int CYCLE_LIMIT = 700_000;
    localparam int HS_LIMIT    = 32;
    localparam int SPIN_WAIT   = 65_544;

    // Keyboard bits in priority order and the key code each one selects
    localparam int KEY_ORDER [12] = '{13, 7, 12, 2, 3, 14, 5, 1, 11, 10, 9, 6};
    localparam int KEY_CODE  [12] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 0, 10, 11};
    localparam logic [3:0] KEY_PINS [13] = '{
        4'b0011, 4'b1110, 4'b1101, 4'b0110, 4'b0001, 4'b1001, 4'b0111,
        4'b1100, 4'b1000, 4'b1011, 4'b1010, 4'b0101, 4'b1111
    };

    logic                    clk_sys;
    logic                    reset;
    cv_axil_req_t            axil_req;
    cv_axil_rsp_t            axil_rsp;
    cv_ctrl_sel_t            ctrl_sel [NUM_PORTS];
    cv_joy_t                 joy0;
    cv_joy_t                 joy1;
    logic [15:0]             ps2_keys;
    logic [4:0]              ps2_joy;
    cv_ctrl_out_t            ctrl_out [NUM_PORTS];
    logic [CPU_ADDR_W-1:0]   cpu_ram_a;
    logic [CPU_ADDR_W-1:0]   ram_a;
    cv_dl_t                  dl;
    logic                    console_reset;

    logic [31:0] rng;
    logic [31:0] wdata_r;
    logic [31:0] rdata_r;
    logic        dahjee_pred;
    logic [1:0]  quad_model [NUM_PORTS];
    int          errors;
    int          checks;
    int          errors_mark;
    int          checks_mark;
    int          cycles;

    cv_glue_top dut (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .axil_req_i      (axil_req),
        .axil_rsp_o      (axil_rsp),
        .ctrl_sel_i      (ctrl_sel),
        .joy0_i          (joy0),
        .joy1_i          (joy1),
        .ps2_keys_i      (ps2_keys),
        .ps2_joy_i       (ps2_joy),
        .ctrl_o          (ctrl_out),
        .cpu_ram_a_i     (cpu_ram_a),
        .ram_a_o         (ram_a),
        .dl_i            (dl),
        .console_reset_o (console_reset)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("Run stopped after %0d cycles without reaching the end", cycles);
        $display("Test failed");
        $finish;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Lowest priority first so the highest pressed key is the last one kept
    function automatic int key_code_of(input logic [15:0] keys);
        int code;
        code = 12;
        for (int i = 11; i >= 0; i--) begin
            if (keys[KEY_ORDER[i]]) code = KEY_CODE[i];
        end
        return code;
    endfunction

    // Expected {pin 1..4, fire} for a port select of {sel_joy, sel_key}
    function automatic logic [4:0] port_model(input logic [1:0] sel, input logic [15:0] keys,
                                              input logic [4:0] pjoy, input logic [7:0] joy);
        logic [4:0] res;
        case (sel)
            2'b01: res = {KEY_PINS[key_code_of(keys)], ~(keys[0] | joy[5])};
            2'b10: res = {~(pjoy[0] | joy[3]), ~(pjoy[1] | joy[2]), ~(pjoy[2] | joy[1]),
                          ~(pjoy[3] | joy[0]), ~(pjoy[4] | joy[4])};
            default: res = 5'b11111;
        endcase
        return res;
    endfunction

    function automatic logic [14:0] map_model(input logic [14:0] a, input logic [1:0] rs,
                                              input logic sg, input logic dj);
        if (sg && dj) return a;
        if (sg && !a[14]) return {1'b1, a[13:0]};
        if (rs == 2'd1) return {2'b00, a[12:0]};
        if (rs == 2'd0) return {5'b00000, a[9:0]};
        if (sg) return {1'b0, a[13:0]};
        return a;
    endfunction

    function automatic logic [1:0] next_quad(input logic [1:0] q, input logic l, input logic r);
        if (l) return (q == 2'b11) ? 2'b10 : (q == 2'b10) ? 2'b00 : (q == 2'b00) ? 2'b01 : 2'b11;
        if (r) return (q == 2'b11) ? 2'b01 : (q == 2'b01) ? 2'b00 : (q == 2'b00) ? 2'b10 : 2'b11;
        return q;
    endfunction

    // --------------------------------------------------
    // Checks and bus tasks
    // --------------------------------------------------
    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("%-10s checks %0d, errors %0d", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk_sys);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.bready  = 1'b1;
        while (!(axil_rsp.awready && axil_rsp.wready) && waited < HS_LIMIT) begin
            @(negedge clk_sys);
            waited++;
        end
        // Handshake completes on the edge in between
        @(negedge clk_sys);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid && waited < HS_LIMIT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (waited >= HS_LIMIT) begin
            errors++;
            $display("Write to address %0h got no response within %0d cycles", addr, HS_LIMIT);
        end else begin
            compare(axil_rsp.bresp, 2'b00, "write response");
        end
        @(negedge clk_sys);
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        int waited;
        waited = 0;
        data   = '0;
        @(negedge clk_sys);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        while (!axil_rsp.arready && waited < HS_LIMIT) begin
            @(negedge clk_sys);
            waited++;
        end
        @(negedge clk_sys);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid && waited < HS_LIMIT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (waited >= HS_LIMIT) begin
            errors++;
            $display("Read from address %0h got no data within %0d cycles", addr, HS_LIMIT);
        end else begin
            data = axil_rsp.rdata;
            compare(axil_rsp.rresp, 2'b00, "read response");
        end
        @(negedge clk_sys);
        axil_req.rready = 1'b0;
    endtask

    task automatic check_ports(input logic swap);
        logic [7:0] src;
        for (int p = 0; p < NUM_PORTS; p++) begin
            src = ((p == 1) != swap) ? joy1 : joy0;
            compare({ctrl_out[p].pins.key_pattern, ctrl_out[p].fire},
                    port_model(ctrl_sel[p], ps2_keys, ps2_joy, src),
                    $sformatf("port %0d pins and fire", p));
        end
    endtask

    task automatic sweep_ram_map(input int per_combo);
        for (int rs = 0; rs < 4; rs++) begin
            for (int sg = 0; sg < 2; sg++) begin
                axi_write(REG_CFG_ADDR, 32'(rs * 16 + sg * 2));
                for (int k = 0; k < per_combo; k++) begin
                    @(negedge clk_sys);
                    cpu_ram_a = 15'(next_rand());
                    #1;
                    compare(ram_a, map_model(cpu_ram_a, 2'(rs), sg[0], dahjee_pred),
                            "ram address map");
                end
            end
        end
    endtask

    // SG-1000 download through the checksum window, then status and map check
    task automatic run_download(input logic all_ff);
        logic [7:0]  chk;
        logic [7:0]  d;
        logic [15:0] a;
        logic [31:0] rd;
        chk = '0;
        axi_write(REG_CFG_ADDR, 32'h02);
        @(negedge clk_sys);
        dl        = '0;
        dl.active = 1'b1;
        @(negedge clk_sys);
        compare(console_reset, 1'b1, "console reset during download");
        for (int n = 0; n < 25; n++) begin
            if (n == 0) a = 16'h2000;
            else if (n % 4 == 0) a = 16'(next_rand());
            else a = {3'b001, 13'(next_rand())};
            d = all_ff ? 8'hFF : 8'(next_rand() | next_rand());
            if (a == 16'h2000) chk = d;
            else if (a[15:13] == 3'b001) chk = chk & d;
            dl.wr   = 1'b1;
            dl.addr = a;
            dl.data = d;
            @(negedge clk_sys);
        end
        dl = '0;
        dahjee_pred = (chk == 8'hFF);
        axi_read(REG_STAT_ADDR, rd);
        compare(rd, {31'b0, dahjee_pred}, "dahjee status");
        for (int k = 0; k < 8; k++) begin
            @(negedge clk_sys);
            cpu_ram_a = 15'(next_rand());
            #1;
            compare(ram_a, map_model(cpu_ram_a, 2'd0, 1'b1, dahjee_pred), "map after download");
        end
    endtask

    // Waits for each quad change on port 0 and checks both ports
    task automatic spin_steps(input int n);
        logic [1:0] prev;
        logic [1:0] exp0;
        logic [1:0] exp1;
        int         waited;
        for (int s = 0; s < n; s++) begin
            exp0   = next_quad(quad_model[0], joy0[1], joy0[0]);
            exp1   = next_quad(quad_model[1], joy1[1], joy1[0]);
            prev   = ctrl_out[0].quad;
            waited = 0;
            while (ctrl_out[0].quad == prev && waited < SPIN_WAIT) begin
                @(negedge clk_sys);
                waited++;
            end
            if (waited >= SPIN_WAIT) begin
                errors++;
                $display("Spinner on port 0 did not step within %0d cycles", SPIN_WAIT);
                break;
            end
            compare(ctrl_out[0].quad, exp0, "port 0 spinner quad");
            compare(ctrl_out[1].quad, exp1, "port 1 spinner quad");
            quad_model[0] = exp0;
            quad_model[1] = exp1;
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        rng = 32'd59;
        errors = 0;
        checks = 0;
        errors_mark = 0;
        checks_mark = 0;
        dahjee_pred = 1'b0;
        quad_model[0] = 2'b11;
        quad_model[1] = 2'b11;
        reset = 1'b1;
        axil_req = '0;
        ctrl_sel[0] = '0;
        ctrl_sel[1] = '0;
        joy0 = '0;
        joy1 = '0;
        ps2_keys = '0;
        ps2_joy = '0;
        cpu_ram_a = '0;
        dl = '0;

        repeat (5) @(negedge clk_sys);
        compare(console_reset, 1'b1, "console reset during reset");
        compare({axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid, axil_rsp.arready,
                 axil_rsp.rvalid}, 5'b00000, "AXI outputs idle after reset");
        reset = 1'b0;
        @(negedge clk_sys);
        compare(console_reset, 1'b0, "console reset released");
        for (int i = 0; i < 4; i++) begin
            wdata_r = next_rand();
            axi_write(REG_CFG_ADDR, wdata_r);
            axi_read(REG_CFG_ADDR, rdata_r);
            compare(rdata_r, wdata_r & 32'h3F, "CFG readback");
        end
        axi_write(4'h8, next_rand());
        axi_read(4'h8, rdata_r);
        compare(rdata_r, 32'h0, "unmapped read");
        axi_read(REG_CFG_ADDR, rdata_r);
        compare(rdata_r, wdata_r & 32'h3F, "CFG after unmapped write");
        axi_read(REG_STAT_ADDR, rdata_r);
        compare(rdata_r, 32'h0, "STAT after reset");
        axi_write(REG_CFG_ADDR, 32'h01);
        compare(console_reset, 1'b1, "soft reset raises console reset");
        axi_write(REG_CFG_ADDR, 32'h00);
        compare(console_reset, 1'b0, "soft reset cleared");
        report_test("regs");

        // Sparse key masks with every tenth one free of key bits
        for (int i = 0; i < 200; i++) begin
            @(negedge clk_sys);
            ps2_keys = 16'(next_rand() & next_rand());
            if (i % 10 == 0) ps2_keys = ps2_keys & 16'h8011;
            ps2_joy = 5'(next_rand());
            joy0 = 8'(next_rand());
            joy1 = 8'(next_rand());
            ctrl_sel[0] = 2'b01;
            ctrl_sel[1] = 2'(next_rand());
            #1;
            check_ports(1'b0);
        end
        report_test("keypad");

        for (int i = 0; i < 200; i++) begin
            if (i == 100) axi_write(REG_CFG_ADDR, 32'h04);
            @(negedge clk_sys);
            ps2_keys = 16'(next_rand());
            ps2_joy = 5'(next_rand());
            joy0 = 8'(next_rand());
            joy1 = 8'(next_rand());
            ctrl_sel[0] = 2'b10;
            ctrl_sel[1] = 2'b10;
            #1;
            check_ports(i >= 100);
        end
        axi_write(REG_CFG_ADDR, 32'h00);
        report_test("joystick");

        sweep_ram_map(19);
        run_download(1'b1);
        sweep_ram_map(19);
        report_test("ram_map");

        for (int i = 0; i < 6; i++) begin
            run_download(i % 2 == 0);
        end
        report_test("dahjee");

        @(negedge clk_sys);
        joy0 = 8'h02;
        joy1 = 8'h00;
        axi_write(REG_CFG_ADDR, 32'h08);
        compare({ctrl_out[0].quad, ctrl_out[1].quad}, 4'b1111, "spinner idle after enable");
        spin_steps(4);
        // Port 1 holds both directions so left wins
        joy0 = 8'h01;
        joy1 = 8'h03;
        spin_steps(4);
        spin_steps(1);
        axi_write(REG_CFG_ADDR, 32'h00);
        compare({ctrl_out[0].quad, ctrl_out[1].quad}, 4'b1111, "spinner disabled");
        report_test("spinner");

        $display("Total checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
